/* flist.f */
logic/legv8Pkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/coreSequencer.sv
logic/memArbiter.sv
logic/unifiedMem.sv
logic/legv8Top.sv
testbench/tbTop.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tbTop
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tbTop.sv */
`default_nettype none

module tbTop import legv8Pkg::*;
();

	localparam int MemWords = 1024;
	localparam logic [10:0] OpLdur = 11'h7C2;
	localparam logic [10:0] OpStur = 11'h7C0;
	localparam logic [10:0] OpAdd = 11'h458;
	localparam logic [10:0] OpSub = 11'h658;
	localparam logic [10:0] OpAnd = 11'h450;
	localparam logic [10:0] OpOrr = 11'h550;
	localparam logic [9:0] OpAddi = 10'h244;
	localparam logic [7:0] OpCbz = 8'hB4;
	localparam logic [7:0] OpCbnz = 8'hB5;
	localparam logic [5:0] OpB = 6'h05;
	localparam instT InstHalt = 32'hFFE0_0000;
	localparam int Xzr = 31;

	logic clk = 1'b0;
	logic rstN;
	logic start;
	memReqT hostReq;
	memRspT hostRsp;
	logic halted;
	logic illegalOp;

	instT prog [$];
	dataT mdl [int]; // Expected memory by word index
	int hostWords [$];
	int cycle = 0;
	int deadline = 100;
	int checks = 0;
	int checkErrors = 0;
	int timingErrors = 0;
	int quietErrors = 0;
	logic [1:0] hostDly;

	legv8Top #(.MEM_WORDS(MemWords)) dut_i (
		.clk, .rstN, .hostReq, .start,
		.hostRsp, .halted, .illegalOp
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle++;
		if (cycle > deadline)
		begin
			$display("Error: watchdog expired at cycle %0d, the DUT stopped responding", cycle);
			$display("Test FAILED");
			$finish;
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			hostDly <= '0;
		else
			hostDly <= {hostDly[0], hostReq.valid};
	end

	// Host response exactly two cycles after its request
	assert property (@(posedge clk) disable iff (!rstN) hostRsp.valid == hostDly[1])
	else
	begin
		$display("Error: hostRsp.valid did not arrive exactly 2 cycles after hostReq");
		timingErrors++;
	end

	// Core stays quiet once stopped
	assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !dut_i.dataReq.valid && !dut_i.fetchReq.valid)
	else
	begin
		$display("Error: core issued a memory request after it stopped");
		quietErrors++;
	end

	function automatic void extendDeadline(input int n);
		if (cycle + n > deadline)
			deadline = cycle + n;
	endfunction

	function automatic int wordOf(input dataT a);
		return int'(a[15:3]) % MemWords;
	endfunction

	function automatic dataT fillWord(input int word);
		addrT a;
		a = addrT'(word * 8);
		return {~a, a ^ 16'h5A5A, ~a ^ 16'h0F0F, a};
	endfunction

	function automatic instT encR(input logic [10:0] opc, input int rd, input int rn, input int rm);
		return {opc, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
	endfunction

	function automatic instT encI(input int rd, input int rn, input int imm);
		return {OpAddi, 12'(imm), 5'(rn), 5'(rd)};
	endfunction

	function automatic instT encD(input logic [10:0] opc, input int rt, input int rn, input int off);
		return {opc, 9'(off), 2'b00, 5'(rn), 5'(rt)};
	endfunction

	function automatic instT encCB(input logic [7:0] opc, input int rt, input int off);
		return {opc, 19'(off), 5'(rt)};
	endfunction

	function automatic instT instAt(input int i);
		return (i < prog.size()) ? prog[i] : InstHalt;
	endfunction

	// ISA-level model of the program; updates mdl and returns the instruction count
	function automatic int runModel();
		dataT x [32];
		dataT ea;
		dataT result;
		instT inst;
		int pc;
		int nextPc;
		int count;
		logic wr;
		logic done;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		pc = 0;
		count = 0;
		done = 1'b0;
		while (!done && count < 10000)
		begin
			inst = (pc / 4 < prog.size()) ? prog[pc / 4] : '0;
			ea = x[inst[9:5]] + {{55{inst[20]}}, inst[20:12]};
			nextPc = pc + 4;
			result = '0;
			wr = 1'b0;
			count++;
			if (inst[31:21] == OpLdur)
			begin
				result = mdl[wordOf(ea)];
				wr = 1'b1;
			end
			else if (inst[31:21] == OpStur)
				mdl[wordOf(ea)] = x[inst[4:0]];
			else if (inst[31:21] == OpAdd)
			begin
				result = x[inst[9:5]] + x[inst[20:16]];
				wr = 1'b1;
			end
			else if (inst[31:22] == OpAddi)
			begin
				result = x[inst[9:5]] + 64'(inst[21:10]);
				wr = 1'b1;
			end
			else if (inst[31:21] == OpSub)
			begin
				result = x[inst[9:5]] - x[inst[20:16]];
				wr = 1'b1;
			end
			else if (inst[31:21] == OpAnd)
			begin
				result = x[inst[9:5]] & x[inst[20:16]];
				wr = 1'b1;
			end
			else if (inst[31:21] == OpOrr)
			begin
				result = x[inst[9:5]] | x[inst[20:16]];
				wr = 1'b1;
			end
			else if ((inst[31:24] == OpCbz && x[inst[4:0]] == '0)
				|| (inst[31:24] == OpCbnz && x[inst[4:0]] != '0))
				nextPc = pc + 4 * int'($signed(inst[23:5]));
			else if (inst[31:24] == OpCbz || inst[31:24] == OpCbnz)
				nextPc = pc + 4;
			else if (inst[31:26] == OpB)
				nextPc = pc + 4 * int'($signed(inst[25:0]));
			else
				done = 1'b1; // HALT or unknown opcode
			if (wr && inst[4:0] != 5'd31)
				x[inst[4:0]] = result;
			pc = nextPc;
		end
		return count;
	endfunction

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			checkErrors++;
		end
	endtask

	task automatic hostWrite(input int word, input dataT data);
		extendDeadline(20);
		@(posedge clk);
		hostReq <= '{valid: 1'b1, we: 1'b1, addr: addrT'(word * 8), wdata: data};
		@(posedge clk);
		hostReq.valid <= 1'b0;
		do
			@(posedge clk);
		while (!hostRsp.valid);
		mdl[word] = data;
	endtask

	task automatic hostRead(input int word, output dataT data);
		extendDeadline(20);
		@(posedge clk);
		hostReq <= '{valid: 1'b1, we: 1'b0, addr: addrT'(word * 8), wdata: '0};
		@(posedge clk);
		hostReq.valid <= 1'b0;
		do
			@(posedge clk);
		while (!hostRsp.valid);
		data = hostRsp.rdata;
	endtask

	task automatic checkWord(input int word);
		dataT got;
		hostRead(word, got);
		checks++;
		assert (got === mdl[word])
		else
		begin
			$display("Mismatch hostRsp.rdata word %0d: got %h, expected %h", word, got, mdl[word]);
			checkErrors++;
		end
	endtask

	task automatic preloadFill(input int first, input int n);
		for (int w = first; w < first + n; w++)
			hostWrite(w, fillWord(w));
	endtask

	task automatic resetDut();
		extendDeadline(30);
		@(posedge clk);
		rstN <= 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		checkBit("halted", halted, 1'b0);
		checkBit("illegalOp", illegalOp, 1'b0);
	endtask

	task automatic waitHalted();
		do
			@(posedge clk);
		while (!halted);
	endtask

	task automatic runProgram(input logic expectIllegal, input logic hostTraffic);
		int count;
		int runEnd;
		for (int k = 0; k < (prog.size() + 1) / 2; k++)
			hostWrite(k, {instAt(2 * k + 1), instAt(2 * k)}); // Two instructions per word
		count = runModel();
		resetDut();
		extendDeadline(200 * count + 50);
		runEnd = cycle + 200 * count + 50;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		fork
			waitHalted();
			while (hostTraffic && !halted && cycle < runEnd)
				checkWord(hostWords[$urandom % hostWords.size()]);
		join
		checkBit("illegalOp", illegalOp, expectIllegal);
	endtask

	task automatic testHostRoundTrip();
		int word;
		for (int i = 0; i < 12; i++)
		begin
			word = 512 + int'($urandom % 512);
			hostWrite(word, {$urandom, $urandom});
			hostWords.push_back(word);
		end
		for (int i = 0; i < 12; i++)
			checkWord(hostWords[$urandom % hostWords.size()]);
	endtask

	task automatic testArithmetic();
		int a;
		int b;
		a = int'($urandom % 4096);
		b = int'($urandom % 4096);
		preloadFill(256, 8);
		prog.delete();
		prog.push_back(encI(10, Xzr, 'h800));
		prog.push_back(encI(1, Xzr, a));
		prog.push_back(encI(2, Xzr, b));
		prog.push_back(encR(OpAdd, 3, 1, 2));
		prog.push_back(encR(OpSub, 4, 1, 2));
		prog.push_back(encR(OpAnd, 5, 1, 2));
		prog.push_back(encR(OpOrr, 6, 1, 2));
		prog.push_back(encI(Xzr, 1, 5)); // Write aimed at X31
		for (int r = 1; r <= 6; r++)
			prog.push_back(encD(OpStur, r, 10, 8 * (r - 1)));
		prog.push_back(encD(OpStur, Xzr, 10, 48));
		prog.push_back(InstHalt);
		prog.push_back(encD(OpStur, 1, 10, 56)); // Never reached
		runProgram(1'b0, 1'b0);
		for (int w = 256; w < 264; w++)
			checkWord(w);
		checkBit("halted", halted, 1'b1); // Still set after the readback
	endtask

	task automatic testLoadStore();
		preloadFill(298, 10);
		for (int w = 300; w < 303; w++)
			hostWrite(w, {$urandom, $urandom});
		prog.delete();
		prog.push_back(encI(10, Xzr, 'h960));
		prog.push_back(encD(OpLdur, 1, 10, 0));
		prog.push_back(encD(OpLdur, 2, 10, 8));
		prog.push_back(encD(OpLdur, 3, 10, 16));
		prog.push_back(encR(OpAdd, 4, 1, 2));
		prog.push_back(encR(OpSub, 5, 4, 3));
		prog.push_back(encR(OpOrr, 6, 1, 3));
		prog.push_back(encD(OpStur, 4, 10, 32));
		prog.push_back(encD(OpStur, 5, 10, -8));
		prog.push_back(encD(OpStur, 6, 10, 48));
		prog.push_back(InstHalt);
		runProgram(1'b0, 1'b0);
		for (int w = 298; w < 308; w++)
			checkWord(w);
		checkBit("halted", halted, 1'b1);
	endtask

	task automatic testBranches(input logic hostTraffic);
		preloadFill(320, 5);
		prog.delete();
		prog.push_back(encI(10, Xzr, 'hA00));
		prog.push_back(encI(11, Xzr, 1));
		prog.push_back(encI(1, Xzr, 3 + int'($urandom % 6)));
		prog.push_back(encI(2, 2, 3)); // Loop body
		prog.push_back(encR(OpSub, 1, 1, 11));
		prog.push_back(encCB(OpCbnz, 1, -2));
		prog.push_back(encCB(OpCbz, 1, 2)); // Taken
		prog.push_back(encD(OpStur, 2, 10, 0));
		prog.push_back(encCB(OpCbz, 2, 2)); // Not taken
		prog.push_back(encD(OpStur, 2, 10, 8));
		prog.push_back({OpB, 26'd2});
		prog.push_back(encD(OpStur, 11, 10, 16)); // Jumped over
		prog.push_back(encD(OpStur, 1, 10, 24));
		prog.push_back(InstHalt);
		runProgram(1'b0, hostTraffic);
		for (int w = 320; w < 325; w++)
			checkWord(w);
		checkBit("halted", halted, 1'b1);
	endtask

	task automatic testIllegal();
		preloadFill(352, 1);
		prog.delete();
		prog.push_back(encI(10, Xzr, 'hB00));
		prog.push_back(encI(1, Xzr, 7));
		prog.push_back(32'h0000_0000); // Unknown opcode
		prog.push_back(encD(OpStur, 1, 10, 0));
		prog.push_back(InstHalt);
		runProgram(1'b1, 1'b0);
		checkWord(352);
		checkBit("halted", halted, 1'b1);
	endtask

	initial
	begin
		void'($urandom(32'h63cc));
		rstN <= 1'b0;
		start <= 1'b0;
		hostReq <= '0;
		resetDut();
		testHostRoundTrip();
		testArithmetic();
		testLoadStore();
		testBranches(1'b0);
		testIllegal();
		testBranches(1'b1); // Host reads while the core runs
		$display("Checks: %0d, check errors: %0d, timing errors: %0d, quiet errors: %0d",
			checks, checkErrors, timingErrors, quietErrors);
		if (checkErrors == 0 && timingErrors == 0 && quietErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/legv8Top.sv */
`default_nettype none

module legv8Top import legv8Pkg::*;
#(
	parameter int MEM_WORDS = 1024
)
(
	input logic clk,
	input logic rstN,
	input memReqT hostReq,
	input logic start,
	output memRspT hostRsp,
	output logic halted,
	output logic illegalOp
);

	memReqT fetchReq, dataReq, memReq;
	memRspT fetchRsp, dataRsp, memRsp;

	coreSequencer core_i (
		.clk, .rstN, .start,
		.fetchRsp, .dataRsp,
		.fetchReq, .dataReq,
		.halted, .illegalOp
	);

	memArbiter #(.MEM_WORDS(MEM_WORDS)) arb_i (
		.clk, .rstN,
		.hostReq, .dataReq, .fetchReq,
		.memRsp, .memReq,
		.hostRsp, .dataRsp, .fetchRsp
	);

	unifiedMem #(.MEM_WORDS(MEM_WORDS)) mem_i (
		.clk, .rstN,
		.req(memReq),
		.rsp(memRsp)
	);

endmodule

`default_nettype wire

/* logic/unifiedMem.sv */
`default_nettype none

module unifiedMem import legv8Pkg::*;
#(
	parameter int MEM_WORDS = 1024
)
(
	input logic clk,
	input logic rstN,
	input memReqT req,
	output memRspT rsp
);

	localparam int IdxW = $clog2(MEM_WORDS);

	dataT mem [MEM_WORDS];
	dataT rdataQ;
	logic validQ;
	logic [IdxW-1:0] wordIdx;

	assign wordIdx = IdxW'(req.addr[15:3] % MEM_WORDS); // Bits 2:0 ignored

	always_ff @(posedge clk)
	begin
		if (req.valid)
		begin
			if (req.we)
				mem[wordIdx] <= req.wdata;
			rdataQ <= mem[wordIdx]; // Read-first
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= req.valid;
	end

	assign rsp = '{valid: validQ, rdata: rdataQ};

endmodule

`default_nettype wire

/* logic/memArbiter.sv */
`default_nettype none

module memArbiter import legv8Pkg::*;
#(
	parameter int MEM_WORDS = 1024
)
(
	input logic clk,
	input logic rstN,
	input memReqT hostReq,
	input memReqT dataReq,
	input memReqT fetchReq,
	input memRspT memRsp,
	output memReqT memReq,
	output memRspT hostRsp,
	output memRspT dataRsp,
	output memRspT fetchRsp
);

	// Slot 0 is host, 1 is data, 2 is fetch; lower index wins
	memReqT reqIn [3];
	memReqT pend [3];
	memReqT issued;
	logic [2:0] grant;
	logic [2:0] ownerQ;
	logic [12:0] wordIdx;

	assign reqIn[0] = hostReq;
	assign reqIn[1] = dataReq;
	assign reqIn[2] = fetchReq;

	always_comb
	begin
		grant = '0;
		issued = '0;
		for (int i = 2; i >= 0; i--)
		begin
			if (pend[i].valid)
			begin
				grant = '0;
				grant[i] = 1'b1;
				issued = pend[i];
			end
		end
	end

	assign wordIdx = 13'(issued.addr[15:3] % MEM_WORDS);

	always_comb
	begin
		memReq = issued;
		memReq.addr = {wordIdx, 3'b000};
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 3; i++)
				pend[i] <= '0;
			ownerQ <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				if (reqIn[i].valid)
					pend[i] <= reqIn[i];
				else if (grant[i])
					pend[i].valid <= 1'b0; // Served
			end
			ownerQ <= grant;
		end
	end

	assign hostRsp = '{valid: memRsp.valid & ownerQ[0], rdata: memRsp.rdata};
	assign dataRsp = '{valid: memRsp.valid & ownerQ[1], rdata: memRsp.rdata};
	assign fetchRsp = '{valid: memRsp.valid & ownerQ[2], rdata: memRsp.rdata};

endmodule

`default_nettype wire

/* logic/coreSequencer.sv */
`default_nettype none

module coreSequencer import legv8Pkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	input memRspT fetchRsp,
	input memRspT dataRsp,
	output memReqT fetchReq,
	output memReqT dataReq,
	output logic halted,
	output logic illegalOp
);

	seqStateT state;
	addrT pc;
	addrT nextPc;
	addrT brOffset;
	instT ir;
	ctrlT ctrl;
	regIdxT readB;
	dataT dataA, dataB, opA, opB;
	dataT dImm, iImm, aluB, aluResult, aluOut, memData, writeData;
	logic aluZero, zeroQ, taken, writeEn;

	controlDecoder decoder_i (.opcode(ir[31:21]), .ctrl(ctrl));

	assign readB = ctrl.reg2Loc ? ir[4:0] : ir[20:16];
	assign writeEn = (state == sWriteback) && ctrl.regWrite;
	assign writeData = ctrl.memToReg ? memData : aluOut;

	regFile regs_i (.clk, .rstN, .readA(ir[9:5]), .readB, .writeIdx(ir[4:0]),
		.writeEn, .writeData, .dataA, .dataB);

	assign dImm = {{55{ir[20]}}, ir[20:12]};
	assign iImm = {52'b0, ir[21:10]};

	always_comb
	begin
		unique case (ctrl.aluSrc)
			srcDImm: aluB = dImm;
			srcIImm: aluB = iImm;
			default: aluB = opB;
		endcase
	end

	alu alu_i (.func(ctrl.aluFunc), .a(opA), .b(aluB), .result(aluResult), .zero(aluZero));

	// Word offsets scaled to bytes, then cut to the address width
	assign brOffset = ctrl.uncondBranch ? addrT'({{36{ir[25]}}, ir[25:0], 2'b00})
		: addrT'({{43{ir[23]}}, ir[23:5], 2'b00});
	assign taken = ctrl.uncondBranch | (ctrl.branchZero & zeroQ)
		| (ctrl.branchNonZero & ~zeroQ);
	assign nextPc = taken ? pc + brOffset : pc + addrT'(4);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			pc <= '0;
			fetchReq <= '0;
			dataReq <= '0;
			halted <= 1'b0;
			illegalOp <= 1'b0;
		end
		else
		begin
			fetchReq.valid <= 1'b0; // Strobes last one cycle
			dataReq.valid <= 1'b0;
			unique case (state)
				sIdle:
				begin
					if (start)
					begin
						fetchReq <= '{valid: 1'b1, we: 1'b0, addr: pc, wdata: '0};
						state <= sFetch;
					end
				end
				sFetch:
				begin
					if (fetchRsp.valid)
						state <= sDecode;
				end
				sDecode:
				begin
					if (ctrl.illegal || ctrl.halt)
					begin
						halted <= 1'b1;
						illegalOp <= ctrl.illegal;
						state <= sStopped;
					end
					else
						state <= sExecute;
				end
				sExecute:
				begin
					if (ctrl.memRead || ctrl.memWrite)
					begin
						dataReq <= '{valid: 1'b1, we: ctrl.memWrite,
							addr: addrT'(aluResult), wdata: opB};
						state <= sMemory;
					end
					else
						state <= sWriteback;
				end
				sMemory:
				begin
					if (dataRsp.valid)
						state <= sWriteback;
				end
				sWriteback:
				begin
					pc <= nextPc;
					fetchReq <= '{valid: 1'b1, we: 1'b0, addr: nextPc, wdata: '0};
					state <= sFetch;
				end
				default:
				begin
					state <= sStopped; // Held until reset
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == sFetch && fetchRsp.valid)
			ir <= pc[2] ? fetchRsp.rdata[63:32] : fetchRsp.rdata[31:0];
		if (state == sDecode)
		begin
			opA <= dataA;
			opB <= dataB;
		end
		if (state == sExecute)
		begin
			aluOut <= aluResult;
			zeroQ <= aluZero;
		end
		if (state == sMemory && dataRsp.valid)
			memData <= dataRsp.rdata;
	end

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

module alu import legv8Pkg::*;
(
	input aluFuncT func,
	input dataT a,
	input dataT b,
	output dataT result,
	output logic zero
);

	always_comb
	begin
		unique case (func)
			aluAdd:
			begin
				result = a + b;
			end
			aluSub:
			begin
				result = a - b;
			end
			aluAnd:
			begin
				result = a & b;
			end
			aluOrr:
			begin
				result = a | b;
			end
			aluPassB:
			begin
				result = b; // CBZ and CBNZ test Rt
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

module regFile import legv8Pkg::*;
(
	input logic clk,
	input logic rstN,
	input regIdxT readA,
	input regIdxT readB,
	input regIdxT writeIdx,
	input logic writeEn,
	input dataT writeData,
	output dataT dataA,
	output dataT dataB
);

	localparam regIdxT ZeroReg = 5'd31;

	dataT regs [32];

	// X31 always reads as zero
	assign dataA = (readA == ZeroReg) ? '0 : regs[readA];
	assign dataB = (readB == ZeroReg) ? '0 : regs[readB];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn && writeIdx != ZeroReg)
		begin
			regs[writeIdx] <= writeData;
		end
	end

endmodule

`default_nettype wire

/* logic/controlDecoder.sv */
`default_nettype none

module controlDecoder import legv8Pkg::*;
(
	input opcodeT opcode,
	output ctrlT ctrl
);

	always_comb
	begin
		ctrl = '0;
		ctrl.aluSrc = srcReg;
		ctrl.aluFunc = aluAdd;
		casez (opcode)
			11'b11111000010: // LDUR
			begin
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = srcDImm;
			end
			11'b11111000000: // STUR
			begin
				ctrl.reg2Loc = 1'b1; // Rt is the store data
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = srcDImm;
			end
			11'b10001011000: // ADD
			begin
				ctrl.regWrite = 1'b1;
			end
			11'b1001000100?: // ADDI
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = srcIImm;
			end
			11'b11001011000: // SUB
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluFunc = aluSub;
			end
			11'b10001010000: // AND
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluFunc = aluAnd;
			end
			11'b10101010000: // ORR
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluFunc = aluOrr;
			end
			11'b10110100???: // CBZ
			begin
				ctrl.reg2Loc = 1'b1;
				ctrl.branchZero = 1'b1;
				ctrl.aluFunc = aluPassB; // Zero test on Rt
			end
			11'b10110101???: // CBNZ
			begin
				ctrl.reg2Loc = 1'b1;
				ctrl.branchNonZero = 1'b1;
				ctrl.aluFunc = aluPassB;
			end
			11'b000101?????: // B
			begin
				ctrl.uncondBranch = 1'b1;
			end
			11'b11111111111: // HALT
			begin
				ctrl.halt = 1'b1;
			end
			default:
			begin
				ctrl.illegal = 1'b1; // All enables stay low
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/legv8Pkg.sv */
`default_nettype none

package legv8Pkg;

	typedef logic [63:0] dataT;
	typedef logic [15:0] addrT; // Byte address
	typedef logic [31:0] instT;
	typedef logic [4:0] regIdxT;
	typedef logic [10:0] opcodeT; // Instruction bits 31:21

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOrr,
		aluPassB
	} aluFuncT;

	typedef enum logic [1:0] {
		srcReg,
		srcDImm, // 9-bit signed D-format offset
		srcIImm // 12-bit unsigned I-format immediate
	} aluSrcT;

	typedef struct packed {
		logic reg2Loc;
		logic uncondBranch;
		logic branchZero;
		logic branchNonZero;
		logic memRead;
		logic memToReg;
		logic memWrite;
		logic regWrite;
		aluSrcT aluSrc;
		aluFuncT aluFunc;
		logic halt;
		logic illegal;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic we;
		addrT addr;
		dataT wdata;
	} memReqT;

	typedef struct packed {
		logic valid;
		dataT rdata;
	} memRspT;

	typedef enum logic [2:0] {
		sIdle,
		sFetch,
		sDecode,
		sExecute,
		sMemory,
		sWriteback,
		sStopped
	} seqStateT;

endpackage

`default_nettype wire
